// ==== design/ex_stage.sv ====
/*
 * ex_stage
 * ALU for logic, shift and arithmetic operations; offers its result
 * as the execute forward and holds it in the execute-to-memory register
 */
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   adv_i,
    input  wire mips_pkg::id_ex_t id_ex_i,
    output mips_pkg::fwd_t        ex_fwd_o,
    output logic                  ex_mem_valid_o,
    output mips_pkg::result_t     ex_mem_o
);

    logic [31:0] alu_res;
    logic [4:0]  shamt;

    // shift amount from op1, which holds sa for the constant forms
    assign shamt = id_ex_i.op1[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            mips_pkg::alu_or:   alu_res = id_ex_i.op1 | id_ex_i.op2;
            mips_pkg::alu_and:  alu_res = id_ex_i.op1 & id_ex_i.op2;
            mips_pkg::alu_xor:  alu_res = id_ex_i.op1 ^ id_ex_i.op2;
            mips_pkg::alu_nor:  alu_res = ~(id_ex_i.op1 | id_ex_i.op2);
            mips_pkg::alu_sll:  alu_res = id_ex_i.op2 << shamt;
            mips_pkg::alu_srl:  alu_res = id_ex_i.op2 >> shamt;
            mips_pkg::alu_sra:  alu_res = $signed(id_ex_i.op2) >>> shamt;
            mips_pkg::alu_add:  alu_res = id_ex_i.op1 + id_ex_i.op2;
            mips_pkg::alu_sub:  alu_res = id_ex_i.op1 - id_ex_i.op2;
            mips_pkg::alu_slt:  alu_res = {31'd0, $signed(id_ex_i.op1) < $signed(id_ex_i.op2)};
            mips_pkg::alu_sltu: alu_res = {31'd0, id_ex_i.op1 < id_ex_i.op2};
            default:            alu_res = 32'd0;
        endcase
    end

    assign ex_fwd_o = '{
        wreg:  id_ex_i.valid && id_ex_i.wreg,
        wd:    id_ex_i.wd,
        wdata: alu_res
    };

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_mem_valid_o <= 1'b0;
            ex_mem_o.wreg  <= 1'b0;
        end else if (adv_i) begin
            ex_mem_valid_o <= id_ex_i.valid;
            ex_mem_o.wreg  <= id_ex_i.valid && id_ex_i.wreg;
            ex_mem_o.wd    <= id_ex_i.wd;
            ex_mem_o.wdata <= alu_res;
        end
    end

endmodule

`default_nettype wire

// ==== design/id_decoder.sv ====
/*
 * id_decoder
 * combinational decode of one instruction word into ALU operation,
 * register read enables, destination and immediate operand
 * covers R-type logic, shifts, arithmetic and the immediate forms
 */
`timescale 1ns/1ps
`default_nettype none

module id_decoder (
    input  wire mips_pkg::inst_t inst_i,
    output mips_pkg::ctrl_t      ctrl_o
);

    logic [31:0] imm_zext;
    logic [31:0] imm_sext;
    logic        const_shift;

    assign imm_zext = {16'h0000, inst_i.i.imm16};
    assign imm_sext = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};

    assign const_shift = (inst_i.r.funct == mips_pkg::funct_sll) ||
                         (inst_i.r.funct == mips_pkg::funct_srl) ||
                         (inst_i.r.funct == mips_pkg::funct_sra);

    always_comb begin
        ctrl_o    = '0;
        ctrl_o.wd = inst_i.r.rd;

        case (inst_i.r.op)
            mips_pkg::op_special: begin
                ctrl_o.reg1_read = 1'b1;
                ctrl_o.reg2_read = 1'b1;
                case (inst_i.r.funct)
                    mips_pkg::funct_or:   ctrl_o.alu_op = mips_pkg::alu_or;
                    mips_pkg::funct_and:  ctrl_o.alu_op = mips_pkg::alu_and;
                    mips_pkg::funct_xor:  ctrl_o.alu_op = mips_pkg::alu_xor;
                    mips_pkg::funct_nor:  ctrl_o.alu_op = mips_pkg::alu_nor;
                    mips_pkg::funct_sll:  ctrl_o.alu_op = mips_pkg::alu_sll;
                    mips_pkg::funct_sllv: ctrl_o.alu_op = mips_pkg::alu_sll;
                    mips_pkg::funct_srl:  ctrl_o.alu_op = mips_pkg::alu_srl;
                    mips_pkg::funct_srlv: ctrl_o.alu_op = mips_pkg::alu_srl;
                    mips_pkg::funct_sra:  ctrl_o.alu_op = mips_pkg::alu_sra;
                    mips_pkg::funct_srav: ctrl_o.alu_op = mips_pkg::alu_sra;
                    mips_pkg::funct_add:  ctrl_o.alu_op = mips_pkg::alu_add;
                    mips_pkg::funct_addu: ctrl_o.alu_op = mips_pkg::alu_add;
                    mips_pkg::funct_sub:  ctrl_o.alu_op = mips_pkg::alu_sub;
                    mips_pkg::funct_subu: ctrl_o.alu_op = mips_pkg::alu_sub;
                    mips_pkg::funct_slt:  ctrl_o.alu_op = mips_pkg::alu_slt;
                    mips_pkg::funct_sltu: ctrl_o.alu_op = mips_pkg::alu_sltu;
                    default:              ctrl_o.alu_op = mips_pkg::alu_nop;
                endcase
                // constant shifts carry the amount in sa, with rs zero
                if (const_shift) begin
                    ctrl_o.reg1_read = 1'b0;
                    ctrl_o.imm       = {27'd0, inst_i.r.sa};
                    ctrl_o.wreg      = (inst_i.r.rs == 5'd0);
                end else begin
                    ctrl_o.wreg = (inst_i.r.sa == 5'd0);
                end
                ctrl_o.wreg = ctrl_o.wreg && (ctrl_o.alu_op != mips_pkg::alu_nop);
            end
            mips_pkg::op_ori, mips_pkg::op_andi, mips_pkg::op_xori, mips_pkg::op_lui,
            mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_slti,
            mips_pkg::op_sltiu: begin
                ctrl_o.reg1_read = 1'b1;
                ctrl_o.wreg      = 1'b1;
                ctrl_o.wd        = inst_i.i.rt;
                ctrl_o.imm       = imm_sext;
                case (inst_i.i.op)
                    mips_pkg::op_ori: begin
                        ctrl_o.alu_op = mips_pkg::alu_or;
                        ctrl_o.imm    = imm_zext;
                    end
                    mips_pkg::op_andi: begin
                        ctrl_o.alu_op = mips_pkg::alu_and;
                        ctrl_o.imm    = imm_zext;
                    end
                    mips_pkg::op_xori: begin
                        ctrl_o.alu_op = mips_pkg::alu_xor;
                        ctrl_o.imm    = imm_zext;
                    end
                    // upper half loaded, rs not read
                    mips_pkg::op_lui: begin
                        ctrl_o.alu_op    = mips_pkg::alu_or;
                        ctrl_o.reg1_read = 1'b0;
                        ctrl_o.imm       = {inst_i.i.imm16, 16'h0000};
                    end
                    mips_pkg::op_slti:  ctrl_o.alu_op = mips_pkg::alu_slt;
                    mips_pkg::op_sltiu: ctrl_o.alu_op = mips_pkg::alu_sltu;
                    default:            ctrl_o.alu_op = mips_pkg::alu_add;
                endcase
            end
            default: begin
            end
        endcase

        // unknown words retire as a nop without a write
        if (!ctrl_o.wreg) begin
            ctrl_o.alu_op    = mips_pkg::alu_nop;
            ctrl_o.reg1_read = 1'b0;
            ctrl_o.reg2_read = 1'b0;
            ctrl_o.imm       = '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/id_stage.sv ====
/*
 * id_stage
 * decode stage: register file reads, operand selection with
 * forwarding from execute and memory, and the decode-to-execute register
 */
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  adv_i,
    input  wire                  inst_valid_i,
    input  wire mips_pkg::inst_t inst_i,
    input  wire [31:0]           rdata1_i,
    input  wire [31:0]           rdata2_i,
    input  wire mips_pkg::fwd_t  ex_fwd_i,
    input  wire mips_pkg::fwd_t  mem_fwd_i,
    output logic [4:0]           raddr1_o,
    output logic [4:0]           raddr2_o,
    output mips_pkg::id_ex_t     id_ex_o
);

    mips_pkg::ctrl_t ctrl;
    logic [31:0]     op1;
    logic [31:0]     op2;

    // nearest producer wins, then the register file
    function automatic logic [31:0] pick_operand(
        input logic           rd_en,
        input logic [4:0]     addr,
        input logic [31:0]    rf_data,
        input logic [31:0]    imm,
        input mips_pkg::fwd_t ex,
        input mips_pkg::fwd_t mem
    );
        if (!rd_en) begin
            return imm;
        end
        // r0 is never forwarded
        if (addr == 5'd0) begin
            return rf_data;
        end
        if (ex.wreg && (ex.wd == addr)) begin
            return ex.wdata;
        end
        if (mem.wreg && (mem.wd == addr)) begin
            return mem.wdata;
        end
        return rf_data;
    endfunction

    id_decoder id_decoder_i (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    assign raddr1_o = inst_i.r.rs;
    assign raddr2_o = inst_i.r.rt;

    assign op1 = pick_operand(ctrl.reg1_read, raddr1_o, rdata1_i, ctrl.imm,
                              ex_fwd_i, mem_fwd_i);
    assign op2 = pick_operand(ctrl.reg2_read, raddr2_o, rdata2_i, ctrl.imm,
                              ex_fwd_i, mem_fwd_i);

    // a bubble enters when nothing is transferred
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_ex_o.valid <= 1'b0;
            id_ex_o.wreg  <= 1'b0;
        end else if (adv_i) begin
            id_ex_o.valid  <= inst_valid_i;
            id_ex_o.wreg   <= inst_valid_i && ctrl.wreg;
            id_ex_o.alu_op <= ctrl.alu_op;
            id_ex_o.wd     <= ctrl.wd;
            id_ex_o.op1    <= op1;
            id_ex_o.op2    <= op2;
        end
    end

endmodule

`default_nettype wire

// ==== design/int_core.sv ====
/*
 * int_core
 * top of the integer pipeline: decode, execute and writeback around
 * the register file, with instructions in and results out over
 * valid/ready; the whole pipe stalls while a result is refused
 */
`timescale 1ns/1ps
`default_nettype none

module int_core (
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  inst_valid_i,
    input  wire mips_pkg::inst_t inst_i,
    output logic                 inst_ready_o,
    output logic                 res_valid_o,
    output mips_pkg::result_t    res_o,
    input  wire                  res_ready_i
);

    logic              adv;
    mips_pkg::id_ex_t  id_ex;
    mips_pkg::fwd_t    ex_fwd;
    mips_pkg::fwd_t    mem_fwd;
    logic              ex_mem_valid;
    mips_pkg::result_t ex_mem;
    logic              we;
    logic [4:0]        raddr1;
    logic [4:0]        raddr2;
    logic [31:0]       rdata1;
    logic [31:0]       rdata2;

    // global stall
    assign adv          = !(res_valid_o && !res_ready_i);
    assign inst_ready_o = adv;

    id_stage id_stage_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .adv_i        (adv),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rdata1_i     (rdata1),
        .rdata2_i     (rdata2),
        .ex_fwd_i     (ex_fwd),
        .mem_fwd_i    (mem_fwd),
        .raddr1_o     (raddr1),
        .raddr2_o     (raddr2),
        .id_ex_o      (id_ex)
    );

    ex_stage ex_stage_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .adv_i          (adv),
        .id_ex_i        (id_ex),
        .ex_fwd_o       (ex_fwd),
        .ex_mem_valid_o (ex_mem_valid),
        .ex_mem_o       (ex_mem)
    );

    wb_stage wb_stage_i (
        .adv_i          (adv),
        .ex_mem_valid_i (ex_mem_valid),
        .ex_mem_i       (ex_mem),
        .mem_fwd_o      (mem_fwd),
        .we_o           (we),
        .res_valid_o    (res_valid_o),
        .res_o          (res_o)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (raddr1),
        .raddr2_i (raddr2),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .we_i     (we),
        .wr_i     (mem_fwd)
    );

endmodule

`default_nettype wire

// ==== design/mips_pkg.sv ====
/*
 * mips_pkg
 * shared definitions for the integer pipeline: opcode and function
 * encodings of the supported instructions, the two instruction formats,
 * ALU operations and the structs that travel between the stages
 */
`default_nettype none

package mips_pkg;

    // primary opcodes
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_addi    = 6'b001000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_slti    = 6'b001010;
    localparam logic [5:0] op_sltiu   = 6'b001011;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lui     = 6'b001111;

    // function field under op_special
    localparam logic [5:0] funct_sll  = 6'b000000;
    localparam logic [5:0] funct_srl  = 6'b000010;
    localparam logic [5:0] funct_sra  = 6'b000011;
    localparam logic [5:0] funct_sllv = 6'b000100;
    localparam logic [5:0] funct_srlv = 6'b000110;
    localparam logic [5:0] funct_srav = 6'b000111;
    localparam logic [5:0] funct_add  = 6'b100000;
    localparam logic [5:0] funct_addu = 6'b100001;
    localparam logic [5:0] funct_sub  = 6'b100010;
    localparam logic [5:0] funct_subu = 6'b100011;
    localparam logic [5:0] funct_and  = 6'b100100;
    localparam logic [5:0] funct_or   = 6'b100101;
    localparam logic [5:0] funct_xor  = 6'b100110;
    localparam logic [5:0] funct_nor  = 6'b100111;
    localparam logic [5:0] funct_slt  = 6'b101010;
    localparam logic [5:0] funct_sltu = 6'b101011;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // one instruction word, seen as either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_t;

    typedef enum logic [3:0] {
        alu_nop,
        alu_or,
        alu_and,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu
    } alu_op_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        reg1_read;
        logic        reg2_read;
        logic        wreg;
        logic [4:0]  wd;
        logic [31:0] imm;
    } ctrl_t;

    // a register write still on its way to the register file
    typedef struct packed {
        logic        wreg;
        logic [4:0]  wd;
        logic [31:0] wdata;
    } fwd_t;

    typedef struct packed {
        logic        valid;
        alu_op_t     alu_op;
        logic        wreg;
        logic [4:0]  wd;
        logic [31:0] op1;
        logic [31:0] op2;
    } id_ex_t;

    typedef struct packed {
        logic        wreg;
        logic [4:0]  wd;
        logic [31:0] wdata;
    } result_t;

endpackage

`default_nettype wire

// ==== design/reg_file.sv ====
/*
 * reg_file
 * 32 x 32-bit general purpose registers, two combinational read
 * ports and one synchronous write port; r0 always reads zero
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                 clk,
    input  wire                 rst_n_i,
    input  wire [4:0]           raddr1_i,
    input  wire [4:0]           raddr2_i,
    output logic [31:0]         rdata1_o,
    output logic [31:0]         rdata2_o,
    input  wire                 we_i,
    input  wire mips_pkg::fwd_t wr_i
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we_i && wr_i.wreg && (wr_i.wd != 5'd0)) begin
            regs[wr_i.wd] <= wr_i.wdata;
        end
    end

    assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== design/wb_stage.sv ====
/*
 * wb_stage
 * retires the instruction held after execute: presents it on the
 * result stream, exposes its pending write as the memory forward and
 * writes the register file on the edge where the result is taken
 */
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  wire                    adv_i,
    input  wire                    ex_mem_valid_i,
    input  wire mips_pkg::result_t ex_mem_i,
    output mips_pkg::fwd_t         mem_fwd_o,
    output logic                   we_o,
    output logic                   res_valid_o,
    output mips_pkg::result_t      res_o
);

    logic pending_wr;

    assign pending_wr = ex_mem_valid_i && ex_mem_i.wreg;

    assign res_valid_o = ex_mem_valid_i;
    assign res_o       = ex_mem_i;

    assign mem_fwd_o = '{
        wreg:  pending_wr,
        wd:    ex_mem_i.wd,
        wdata: ex_mem_i.wdata
    };

    // with a valid result held, adv is high only when it is accepted
    assign we_o = pending_wr && adv_i;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the int_core testbench with Verilator
verilator --binary --timing --assert --top-module tb_int_core -f sim.f \
    && ./obj_dir/Vtb_int_core | tee /dev/stderr | grep -qx "Testbench passed" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation did not pass"; exit 1; }

// ==== sim.f ====
design/mips_pkg.sv
design/id_decoder.sv
design/id_stage.sv
design/ex_stage.sv
design/wb_stage.sv
design/reg_file.sv
design/int_core.sv
tests/int_core_sva.sv
tests/tb_int_core.sv

// ==== tests/int_core_sva.sv ====
/*
 * int_core_sva
 * checks on the result handshake: a refused result holds still,
 * a stalled input side holds the decode-to-execute register, and
 * reset leaves no result pending
 */
`timescale 1ns/1ps
`default_nettype none

module int_core_sva (
    input wire                    clk,
    input wire                    rst_n_i,
    input wire                    inst_ready_o,
    input wire                    res_valid_o,
    input wire mips_pkg::result_t res_o,
    input wire                    res_ready_i,
    input wire mips_pkg::id_ex_t  id_ex_i
);

    // refused result still offered and unchanged next cycle
    held_result_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o))
    ) else $error("held result changed or dropped while refused");

    stall_holds_id_ex: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !inst_ready_o |=> $stable(id_ex_i)
    ) else $error("decode-to-execute register changed while inst_ready_o was low");

    // synchronous reset clears the result stage
    no_result_after_reset: assert property (
        @(posedge clk)
        !rst_n_i |=> !res_valid_o
    ) else $error("res_valid_o high in the cycle after reset");

endmodule

`default_nettype wire

// ==== tests/tb_int_core.sv ====
/*
 * tb_int_core
 * directed tests for the integer pipeline: immediates, R-type chains
 * with forwarding, shifts, random back-pressure and r0 / unknown words,
 * all checked against a software register model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_int_core;

    // generous bound over the summed length of all tests
    localparam int max_cycles = 2000;

    logic              clk = 1'b0;
    logic              rst_n_i;
    logic              inst_valid_i;
    mips_pkg::inst_t   inst_i;
    logic              inst_ready_o;
    logic              res_valid_o;
    mips_pkg::result_t res_o;
    logic              res_ready_i = 1'b1;

    integer            seed;
    int                cycles = 0;
    int                errors = 0;
    int                test_errors = 0;
    int                tests_run = 0;
    int                results_seen = 0;
    int                last_inst_cycle = 0;
    int                last_res_cycle = 0;
    logic              bp_en = 1'b0;
    string             cur_test = "none";
    logic [31:0]       model_regs [32];
    mips_pkg::result_t exp_q [$];
    mips_pkg::result_t exp_res;

    logic [5:0] imm_ops [8] = '{
        mips_pkg::op_ori, mips_pkg::op_andi, mips_pkg::op_xori, mips_pkg::op_lui,
        mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu
    };
    logic [5:0] r_functs [16] = '{
        mips_pkg::funct_sll, mips_pkg::funct_srl, mips_pkg::funct_sra,
        mips_pkg::funct_sllv, mips_pkg::funct_srlv, mips_pkg::funct_srav,
        mips_pkg::funct_add, mips_pkg::funct_addu, mips_pkg::funct_sub,
        mips_pkg::funct_subu, mips_pkg::funct_and, mips_pkg::funct_or,
        mips_pkg::funct_xor, mips_pkg::funct_nor, mips_pkg::funct_slt, mips_pkg::funct_sltu
    };

    int_core int_core_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_ready_o (inst_ready_o),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o),
        .res_ready_i  (res_ready_i)
    );

    bind int_core int_core_sva int_core_sva_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_ready_o (inst_ready_o),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o),
        .res_ready_i  (res_ready_i),
        .id_ex_i      (id_ex)
    );

    always #2 clk = ~clk;

    // refuse roughly one result in four while back-pressure is on
    always @(negedge clk) begin
        res_ready_i = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", max_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    // result monitor, in order against the model queue
    always @(posedge clk) begin
        if (rst_n_i && res_valid_o && res_ready_i) begin
            results_seen++;
            last_res_cycle = cycles;
            if (exp_q.size() == 0) begin
                $display("%s: result arrived with no instruction outstanding", cur_test);
                errors++;
                test_errors++;
            end else begin
                exp_res = exp_q.pop_front();
                if (exp_res.wreg) begin
                    check_val(cur_test, {26'd0, exp_res}, {26'd0, res_o});
                end else begin
                    check_val(cur_test, {63'd0, exp_res.wreg}, {63'd0, res_o.wreg});
                end
            end
        end
    end

    function automatic logic [31:0] enc_r(input logic [5:0] fn,
                                          input logic [4:0] rs, rt, rd, sa);
        return {mips_pkg::op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] rand_word(input logic [31:0] r);
        logic [5:0] fn;
        fn = r_functs[r[29:26]];
        if (r[31]) begin
            return enc_i(imm_ops[r[28:26]], r[25:21], r[20:16], r[15:0]);
        end
        if (fn == mips_pkg::funct_sll || fn == mips_pkg::funct_srl ||
            fn == mips_pkg::funct_sra) begin
            return enc_r(fn, 5'd0, r[20:16], r[15:11], r[10:6]);
        end
        return enc_r(fn, r[25:21], r[20:16], r[15:11], 5'd0);
    endfunction

    // ISA-level model: one instruction in program order
    task automatic model_exec(input logic [31:0] w, output mips_pkg::result_t res);
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  sa;
        logic [5:0]  fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] zx;
        logic [31:0] sx;
        rs = w[25:21];
        rt = w[20:16];
        sa = w[10:6];
        fn = w[5:0];
        a = model_regs[rs];
        b = model_regs[rt];
        zx = {16'h0000, w[15:0]};
        sx = {{16{w[15]}}, w[15:0]};
        res = '0;
        res.wreg = 1'b1;
        res.wd = rt;
        case (w[31:26])
            mips_pkg::op_ori:   res.wdata = a | zx;
            mips_pkg::op_andi:  res.wdata = a & zx;
            mips_pkg::op_xori:  res.wdata = a ^ zx;
            mips_pkg::op_lui:   res.wdata = {w[15:0], 16'h0000};
            mips_pkg::op_addi,
            mips_pkg::op_addiu: res.wdata = a + sx;
            mips_pkg::op_slti:  res.wdata = {31'd0, ($signed(a) < $signed(sx))};
            mips_pkg::op_sltiu: res.wdata = {31'd0, (a < sx)};
            mips_pkg::op_special: begin
                res.wd = w[15:11];
                case (fn)
                    mips_pkg::funct_sll:  res.wdata = b << sa;
                    mips_pkg::funct_srl:  res.wdata = b >> sa;
                    mips_pkg::funct_sra:  res.wdata = $signed(b) >>> sa;
                    mips_pkg::funct_sllv: res.wdata = b << a[4:0];
                    mips_pkg::funct_srlv: res.wdata = b >> a[4:0];
                    mips_pkg::funct_srav: res.wdata = $signed(b) >>> a[4:0];
                    mips_pkg::funct_add,
                    mips_pkg::funct_addu: res.wdata = a + b;
                    mips_pkg::funct_sub,
                    mips_pkg::funct_subu: res.wdata = a - b;
                    mips_pkg::funct_and:  res.wdata = a & b;
                    mips_pkg::funct_or:   res.wdata = a | b;
                    mips_pkg::funct_xor:  res.wdata = a ^ b;
                    mips_pkg::funct_nor:  res.wdata = ~(a | b);
                    mips_pkg::funct_slt:  res.wdata = {31'd0, ($signed(a) < $signed(b))};
                    mips_pkg::funct_sltu: res.wdata = {31'd0, (a < b)};
                    default:              res.wreg = 1'b0;
                endcase
                // sa-form shifts need rs zero, everything else sa zero
                if (fn == mips_pkg::funct_sll || fn == mips_pkg::funct_srl ||
                    fn == mips_pkg::funct_sra) begin
                    res.wreg = res.wreg && (rs == 5'd0);
                end else begin
                    res.wreg = res.wreg && (sa == 5'd0);
                end
            end
            default: res.wreg = 1'b0;
        endcase
        if (res.wreg && res.wd != 5'd0) begin
            model_regs[res.wd] = res.wdata;
        end
    endtask

    task automatic send(input logic [31:0] word);
        mips_pkg::result_t res;
        @(negedge clk);
        inst_valid_i = 1'b1;
        inst_i = word;
        model_exec(word, res);
        exp_q.push_back(res);
        do begin
            @(posedge clk);
        end while (!inst_ready_o);
        last_inst_cycle = cycles;
    endtask

    task automatic drain();
        @(negedge clk);
        inst_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic report_test();
        $display("test %s: %0d errors", cur_test, test_errors);
    endtask

    task automatic reset_and_latency();
        start_test("reset_latency");
        check_val(cur_test, 64'd0, {63'd0, res_valid_o});
        check_val(cur_test, 64'd1, {63'd0, inst_ready_o});
        send(enc_i(mips_pkg::op_ori, 5'd0, 5'd1, 16'h1234));
        drain();
        check_val(cur_test, 64'd2, 64'(last_res_cycle - last_inst_cycle));
        report_test();
    endtask

    task automatic immediate_forms();
        start_test("immediates");
        send(enc_i(mips_pkg::op_ori, 5'd0, 5'd1, 16'h8001));
        send(enc_i(mips_pkg::op_andi, 5'd1, 5'd2, 16'hf00f));
        send(enc_i(mips_pkg::op_xori, 5'd1, 5'd3, 16'hffff));
        send(enc_i(mips_pkg::op_lui, 5'd0, 5'd4, 16'habcd));
        send(enc_i(mips_pkg::op_addi, 5'd1, 5'd5, 16'hfffe));
        send(enc_i(mips_pkg::op_addiu, 5'd0, 5'd6, 16'h8000));
        send(enc_i(mips_pkg::op_slti, 5'd6, 5'd7, 16'hffff));
        send(enc_i(mips_pkg::op_sltiu, 5'd1, 5'd8, 16'hffff));
        send(enc_i(mips_pkg::op_slti, 5'd1, 5'd9, 16'hfffb));
        drain();
        report_test();
    endtask

    // each one reads the previous one or two destinations
    task automatic rtype_chain();
        start_test("rtype_forwarding");
        send(enc_r(mips_pkg::funct_addu, 5'd1, 5'd3, 5'd10, 5'd0));
        send(enc_r(mips_pkg::funct_sub, 5'd10, 5'd1, 5'd11, 5'd0));
        send(enc_r(mips_pkg::funct_or, 5'd10, 5'd11, 5'd12, 5'd0));
        send(enc_r(mips_pkg::funct_and, 5'd12, 5'd10, 5'd13, 5'd0));
        send(enc_r(mips_pkg::funct_xor, 5'd13, 5'd12, 5'd14, 5'd0));
        send(enc_r(mips_pkg::funct_nor, 5'd14, 5'd13, 5'd15, 5'd0));
        send(enc_r(mips_pkg::funct_slt, 5'd6, 5'd15, 5'd16, 5'd0));
        send(enc_r(mips_pkg::funct_sltu, 5'd6, 5'd15, 5'd17, 5'd0));
        send(enc_r(mips_pkg::funct_add, 5'd17, 5'd16, 5'd18, 5'd0));
        send(enc_r(mips_pkg::funct_subu, 5'd18, 5'd6, 5'd19, 5'd0));
        drain();
        report_test();
    endtask

    task automatic shift_forms();
        start_test("shifts");
        send(enc_i(mips_pkg::op_lui, 5'd0, 5'd20, 16'h8000));
        // 37 in rs, so only the low five bits may count
        send(enc_i(mips_pkg::op_ori, 5'd0, 5'd21, 16'h0025));
        send(enc_r(mips_pkg::funct_sll, 5'd0, 5'd1, 5'd22, 5'd4));
        send(enc_r(mips_pkg::funct_srl, 5'd0, 5'd20, 5'd23, 5'd31));
        send(enc_r(mips_pkg::funct_sra, 5'd0, 5'd20, 5'd24, 5'd4));
        send(enc_r(mips_pkg::funct_sllv, 5'd21, 5'd1, 5'd25, 5'd0));
        send(enc_r(mips_pkg::funct_srlv, 5'd21, 5'd20, 5'd26, 5'd0));
        send(enc_r(mips_pkg::funct_srav, 5'd21, 5'd20, 5'd27, 5'd0));
        drain();
        report_test();
    endtask

    task automatic random_backpressure();
        int          seen_before;
        logic [31:0] r;
        start_test("backpressure");
        seen_before = results_seen;
        bp_en = 1'b1;
        for (int n = 0; n < 40; n++) begin
            r = $random(seed);
            send(rand_word(r));
        end
        drain();
        bp_en = 1'b0;
        check_val(cur_test, 64'd40, 64'(results_seen - seen_before));
        report_test();
    endtask

    task automatic r0_and_unknown();
        start_test("r0_unknown");
        send(32'hfc22_0000);
        send(enc_r(6'b111111, 5'd1, 5'd2, 5'd3, 5'd0));
        send(enc_r(mips_pkg::funct_add, 5'd1, 5'd2, 5'd3, 5'd3));
        send(enc_i(mips_pkg::op_ori, 5'd1, 5'd0, 16'h0055));
        send(enc_r(mips_pkg::funct_addu, 5'd0, 5'd0, 5'd28, 5'd0));
        send(enc_r(mips_pkg::funct_or, 5'd0, 5'd2, 5'd29, 5'd0));
        send(enc_r(mips_pkg::funct_or, 5'd3, 5'd0, 5'd30, 5'd0));
        drain();
        report_test();
    endtask

    initial begin
        seed = 32'h6f63;
        rst_n_i = 1'b0;
        inst_valid_i = 1'b0;
        inst_i = '0;
        foreach (model_regs[i]) begin
            model_regs[i] = 32'd0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        reset_and_latency();
        immediate_forms();
        rtype_chain();
        shift_forms();
        random_backpressure();
        r0_and_unknown();

        $display("%0d tests, %0d results checked, %0d errors", tests_run, results_seen, errors);
        if (errors == 0 && exp_q.size() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
